/* project.f */
design/mem_pkg.sv
design/req_sequencer.sv
design/obi_adapter.sv
design/obi_sram.sv
design/mem_subsys_top.sv
verification/mem_subsys_checker.sv
verification/mem_subsys_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f project.f --top-module mem_subsys_tb -o mem_subsys_sim

# The log decides the verdict, so a failing run must not end the script here
./obj_dir/mem_subsys_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

/* verification/mem_subsys_tb.sv */
module mem_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned MEM_WORDS      = 256;
  localparam int unsigned REFRESH_PERIOD = 7;
  localparam int unsigned REFRESH_LEN    = 2;
  localparam int unsigned IDX_W          = $clog2(MEM_WORDS);
  localparam int          ACK_TIMEOUT    = 100;

  logic           clk = 1'b0;
  logic           rst_n;
  logic           req;
  mem_pkg::addr_t addr;
  logic           we;
  mem_pkg::be_t   be;
  mem_pkg::data_t wdata;
  logic           ack;
  mem_pkg::data_t rdata;
  logic           err;

  logic [31:0]          lfsr_state = 32'ha661e794;
  // Reference copy of the SRAM, a word is trusted only once fully written
  mem_pkg::data_t       ref_mem [MEM_WORDS];
  logic [MEM_WORDS-1:0] written_mask = '0;
  logic [IDX_W-1:0]     written_q [$];
  // Expected responses in issue order
  mem_pkg::data_t       exp_data_q [$];
  logic                 exp_err_q [$];
  mem_pkg::addr_t       cur_addr = '0;
  int                   n_issued = 0;
  int                   n_checked = 0;
  logic                 ack_prev = 1'b0;

  mem_subsys_top #(
    .MEM_WORDS      (MEM_WORDS),
    .REFRESH_PERIOD (REFRESH_PERIOD),
    .REFRESH_LEN    (REFRESH_LEN)
  ) u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_i   (req),
    .addr_i  (addr),
    .we_i    (we),
    .be_i    (be),
    .wdata_i (wdata),
    .ack_o   (ack),
    .rdata_o (rdata),
    .err_o   (err)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////////

  // Right-shifting Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Out of range answers err with zero data, writes answer zero data
  function automatic void ref_model(input mem_pkg::addr_t a, input logic w,
                                    input mem_pkg::be_t b, input mem_pkg::data_t d,
                                    output mem_pkg::data_t exp_d, output logic exp_e);
    mem_pkg::addr_t   word;
    logic [IDX_W-1:0] widx;
    word  = a >> 2;
    widx  = word[IDX_W-1:0];
    exp_d = '0;
    exp_e = (word >= mem_pkg::addr_t'(MEM_WORDS));
    if (!exp_e && w) begin
      for (int i = 0; i < int'(mem_pkg::BE_W); i++) begin
        if (b[i]) begin
          ref_mem[widx][i*8 +: 8] = d[i*8 +: 8];
        end
      end
      if (!written_mask[widx]) begin
        written_mask[widx] = 1'b1;
        written_q.push_back(widx);
      end
    end else if (!exp_e) begin
      exp_d = ref_mem[widx];
    end
  endfunction

  function automatic mem_pkg::addr_t pick_in_range();
    return mem_pkg::addr_t'(rand_bits(IDX_W)) << 2;
  endfunction

  function automatic mem_pkg::addr_t pick_written();
    int k;
    k = int'(rand_bits(16) % written_q.size());
    return mem_pkg::addr_t'(written_q[k]) << 2;
  endfunction

  // A first write to a word must cover all lanes or its old bytes stay unknown
  function automatic mem_pkg::be_t pick_be(input mem_pkg::addr_t a);
    return written_mask[a[IDX_W+1:2]] ? mem_pkg::be_t'(rand_bits(4)) : '1;
  endfunction

  //////////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_data(input string name, input mem_pkg::data_t got,
                            input mem_pkg::data_t exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s expected %h got %h", $time, name, exp, got);
      abort_run("data mismatch");
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s expected %b got %b", $time, name, exp, got);
      abort_run("error flag mismatch");
    end
  endtask

  task automatic check_addr(input string name, input mem_pkg::addr_t got,
                            input mem_pkg::addr_t exp);
    if (got !== exp) begin
      $display("error: time %0t signal %s expected %h got %h", $time, name, exp, got);
      abort_run("address mismatch");
    end
  endtask

  // Every new ack is matched against the oldest expected response
  always @(negedge clk) begin
    if (rst_n && ack && !ack_prev) begin
      if (exp_data_q.size() == 0) begin
        abort_run("ack_o rose with no request outstanding");
      end else begin
        check_data("rdata_o", rdata, exp_data_q.pop_front());
        check_err("err_o", err, exp_err_q.pop_front());
        n_checked++;
      end
    end
    ack_prev = ack;
  end

  // The SRAM must be granted the address the requester issued
  always @(negedge clk) begin
    if (rst_n && u_dut.obi_req && u_dut.obi_gnt) begin
      check_addr("obi_addr", u_dut.obi_addr, cur_addr);
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////////

  // One full four-phase handshake, called on a falling edge
  task automatic run_access(input mem_pkg::addr_t a, input logic w,
                            input mem_pkg::be_t b, input mem_pkg::data_t d);
    mem_pkg::data_t exp_d;
    logic           exp_e;
    int             cycles;
    ref_model(a, w, b, d, exp_d, exp_e);
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    cur_addr = a;
    addr     = a;
    we       = w;
    be       = b;
    wdata    = d;
    req      = 1'b1;
    n_issued++;
    cycles = 0;
    while (!ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) abort_run("timeout waiting for ack_o to rise");
    end
    req = 1'b0;
    cycles = 0;
    while (ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > ACK_TIMEOUT) abort_run("timeout waiting for ack_o to fall");
    end
  endtask

  initial begin
    mem_pkg::addr_t a;
    mem_pkg::be_t   b;
    rst_n = 1'b0;
    req   = 1'b0;
    addr  = '0;
    we    = 1'b0;
    be    = '0;
    wdata = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (ack) abort_run("ack_o high after reset");

    // Full-word write then read back
    a = pick_in_range();
    run_access(a, 1'b1, '1, rand_bits(32));
    run_access(a, 1'b0, '0, '0);

    // Partial writes over a known word
    for (int i = 0; i < 8; i++) begin
      a = pick_in_range();
      run_access(a, 1'b1, '1, rand_bits(32));
      run_access(a, 1'b1, mem_pkg::be_t'(rand_bits(4)), rand_bits(32));
      run_access(a, 1'b0, '0, '0);
    end

    // Random spacing walks the requests across the refresh windows
    for (int i = 0; i < 30; i++) begin
      repeat (rand_bits(3)) @(negedge clk);
      a = (i % 2 == 0) ? pick_in_range() : pick_written();
      b = pick_be(a);
      run_access(a, (i % 2 == 0), b, rand_bits(32));
    end

    // Out of range reads and aliased writes must not touch the array
    for (int i = 0; i < 4; i++) begin
      a = pick_in_range();
      run_access(a, 1'b1, '1, rand_bits(32));
      run_access((mem_pkg::addr_t'(MEM_WORDS) + rand_bits(8)) << 2, 1'b0, '0, '0);
      run_access(a + (mem_pkg::addr_t'(MEM_WORDS) << 2), 1'b1, '1, rand_bits(32));
      run_access(a, 1'b0, '0, '0);
    end

    // Random mix, reads only from words already written
    for (int i = 0; i < 200; i++) begin
      repeat (rand_bits(2)) @(negedge clk);
      if (rand_bits(1) == 32'd1) begin
        a = pick_in_range();
        run_access(a, 1'b1, pick_be(a), rand_bits(32));
      end else begin
        run_access(pick_written(), 1'b0, '0, '0);
      end
    end

    repeat (2) @(negedge clk);
    if (n_checked != n_issued || exp_data_q.size() != 0) begin
      abort_run("not every issued request was acknowledged and checked");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

/* verification/mem_subsys_checker.sv */
module mem_subsys_checker (
  input logic           clk,
  input logic           rst_n,
  input logic           req_i,
  input logic           ack_o,
  input logic           trans_ready,
  input logic           obi_req,
  input logic           obi_gnt,
  input mem_pkg::addr_t obi_addr,
  input logic           obi_we,
  input mem_pkg::be_t   obi_be,
  input mem_pkg::data_t obi_wdata
);
  timeunit 1ns;
  timeprecision 1ps;

  // A request left waiting for grant stays up with its whole A channel frozen
  property a_channel_held_p;
    @(posedge clk) disable iff (!rst_n)
      (obi_req && !obi_gnt) |=> (obi_req && $stable(obi_addr) && $stable(obi_we) &&
                                 $stable(obi_be) && $stable(obi_wdata));
  endproperty

  // An ungranted request puts the adapter into its holding state, where it
  // must refuse new transactions on the following cycle
  property ready_low_while_held_p;
    @(posedge clk) disable iff (!rst_n)
      (obi_req && !obi_gnt) |=> !trans_ready;
  endproperty

  // Ack is only withdrawn once the requester has dropped req
  property ack_falls_after_req_p;
    @(posedge clk) disable iff (!rst_n)
      $fell(ack_o) |-> !$past(req_i);
  endproperty

  a_channel_held: assert property (a_channel_held_p)
    else $error("OBI A channel changed or req dropped before grant");
  ready_low_while_held: assert property (ready_low_while_held_p)
    else $error("trans_ready high while the adapter holds a request");
  ack_falls_after_req: assert property (ack_falls_after_req_p)
    else $error("ack_o fell while req_i was still high");

endmodule

// Bound at the top level where both the four-phase port and the OBI bus are visible
bind mem_subsys_top mem_subsys_checker u_checker (
  .clk         (clk),
  .rst_n       (rst_n),
  .req_i       (req_i),
  .ack_o       (ack_o),
  .trans_ready (trans_ready),
  .obi_req     (obi_req),
  .obi_gnt     (obi_gnt),
  .obi_addr    (obi_addr),
  .obi_we      (obi_we),
  .obi_be      (obi_be),
  .obi_wdata   (obi_wdata)
);

/* design/mem_subsys_top.sv */
module mem_subsys_top #(
  parameter int unsigned MEM_WORDS      = 256,
  parameter int unsigned REFRESH_PERIOD = 7,
  parameter int unsigned REFRESH_LEN    = 2
) (
  input  logic            clk,
  input  logic            rst_n,

  // Four-phase request port
  input  logic            req_i,
  input  mem_pkg::addr_t  addr_i,
  input  logic            we_i,
  input  mem_pkg::be_t    be_i,
  input  mem_pkg::data_t  wdata_i,
  output logic            ack_o,
  output mem_pkg::data_t  rdata_o,
  output logic            err_o
);

  // Sequencer to adapter
  logic           trans_valid;
  logic           trans_ready;
  mem_pkg::addr_t trans_addr;
  logic           trans_we;
  mem_pkg::be_t   trans_be;
  mem_pkg::data_t trans_wdata;
  logic           resp_valid;
  mem_pkg::data_t resp_rdata;
  logic           resp_err;

  // Adapter to SRAM
  logic           obi_req;
  logic           obi_gnt;
  mem_pkg::addr_t obi_addr;
  logic           obi_we;
  mem_pkg::be_t   obi_be;
  mem_pkg::data_t obi_wdata;
  logic           obi_rvalid;
  mem_pkg::data_t obi_rdata;
  logic           obi_err;

  req_sequencer u_req_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (req_i),
    .addr_i        (addr_i),
    .we_i          (we_i),
    .be_i          (be_i),
    .wdata_i       (wdata_i),
    .ack_o         (ack_o),
    .rdata_o       (rdata_o),
    .err_o         (err_o),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .trans_we_o    (trans_we),
    .trans_be_o    (trans_be),
    .trans_wdata_o (trans_wdata),
    .resp_valid_i  (resp_valid),
    .resp_rdata_i  (resp_rdata),
    .resp_err_i    (resp_err)
  );

  obi_adapter u_obi_adapter (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_addr_i  (trans_addr),
    .trans_we_i    (trans_we),
    .trans_be_i    (trans_be),
    .trans_wdata_i (trans_wdata),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .resp_err_o    (resp_err),
    .obi_req_o     (obi_req),
    .obi_gnt_i     (obi_gnt),
    .obi_addr_o    (obi_addr),
    .obi_we_o      (obi_we),
    .obi_be_o      (obi_be),
    .obi_wdata_o   (obi_wdata),
    .obi_rvalid_i  (obi_rvalid),
    .obi_rdata_i   (obi_rdata),
    .obi_err_i     (obi_err)
  );

  // Refresh timing lives only in the SRAM
  obi_sram #(
    .MEM_WORDS      (MEM_WORDS),
    .REFRESH_PERIOD (REFRESH_PERIOD),
    .REFRESH_LEN    (REFRESH_LEN)
  ) u_obi_sram (
    .clk          (clk),
    .rst_n        (rst_n),
    .obi_req_i    (obi_req),
    .obi_gnt_o    (obi_gnt),
    .obi_addr_i   (obi_addr),
    .obi_we_i     (obi_we),
    .obi_be_i     (obi_be),
    .obi_wdata_i  (obi_wdata),
    .obi_rvalid_o (obi_rvalid),
    .obi_rdata_o  (obi_rdata),
    .obi_err_o    (obi_err)
  );

endmodule

/* design/obi_sram.sv */
module obi_sram #(
  parameter int unsigned MEM_WORDS      = 256,
  parameter int unsigned REFRESH_PERIOD = 7,
  parameter int unsigned REFRESH_LEN    = 2
) (
  input  logic            clk,
  input  logic            rst_n,

  // OBI A channel
  input  logic            obi_req_i,
  output logic            obi_gnt_o,
  input  mem_pkg::addr_t  obi_addr_i,
  input  logic            obi_we_i,
  input  mem_pkg::be_t    obi_be_i,
  input  mem_pkg::data_t  obi_wdata_i,

  // OBI R channel
  output logic            obi_rvalid_o,
  output mem_pkg::data_t  obi_rdata_o,
  output logic            obi_err_o
);

  // Word index drops the two byte-offset bits of the address
  localparam int unsigned WIDX_W = mem_pkg::ADDR_W - 2;
  localparam int unsigned MIDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int unsigned CNT_W  = $clog2(REFRESH_PERIOD + 1);

  localparam logic [WIDX_W-1:0] LAST_WORD = WIDX_W'(MEM_WORDS - 1);
  localparam logic [CNT_W-1:0]  LAST_CNT  = CNT_W'(REFRESH_PERIOD - 1);
  localparam logic [CNT_W-1:0]  REF_LEN   = CNT_W'(REFRESH_LEN);

  mem_pkg::data_t mem [MEM_WORDS];

  logic [CNT_W-1:0]  refresh_cnt_q;
  logic              in_refresh;
  logic [WIDX_W-1:0] word_idx;
  logic [MIDX_W-1:0] mem_idx;
  logic              in_range;
  logic              access;

  logic              rvalid_q;
  mem_pkg::data_t    rdata_q;
  logic              err_q;

  //////////////////////////////////////////////////////////////////////////
  // Refresh windows
  //////////////////////////////////////////////////////////////////////////

  // Free-running count from reset, the first REFRESH_LEN counts of each
  // period block the grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      refresh_cnt_q <= '0;
    end else if (refresh_cnt_q == LAST_CNT) begin
      refresh_cnt_q <= '0;
    end else begin
      refresh_cnt_q <= refresh_cnt_q + 1'b1;
    end
  end

  assign in_refresh = (refresh_cnt_q < REF_LEN);
  assign obi_gnt_o  = obi_req_i && !in_refresh;
  assign access     = obi_req_i && obi_gnt_o;

  // Address decode
  assign word_idx = obi_addr_i[mem_pkg::ADDR_W-1:2];
  assign mem_idx  = word_idx[MIDX_W-1:0];
  assign in_range = (word_idx <= LAST_WORD);

  //////////////////////////////////////////////////////////////////////////
  // Array and response
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= access;
    end
  end

  // Out-of-range accesses leave the array alone and answer with an error.
  // Writes answer with zero data
  always_ff @(posedge clk) begin
    if (access) begin
      err_q   <= !in_range;
      rdata_q <= '0;
      if (in_range) begin
        if (obi_we_i) begin
          for (int b = 0; b < mem_pkg::BE_W; b++) begin
            if (obi_be_i[b]) begin
              mem[mem_idx][b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W] <=
                obi_wdata_i[b*mem_pkg::BYTE_W +: mem_pkg::BYTE_W];
            end
          end
        end else begin
          rdata_q <= mem[mem_idx];
        end
      end
    end
  end

  assign obi_rvalid_o = rvalid_q;
  assign obi_rdata_o  = rdata_q;
  assign obi_err_o    = err_q;

endmodule

/* design/obi_adapter.sv */
module obi_adapter (
  input  logic            clk,
  input  logic            rst_n,

  // Transaction request side
  input  logic            trans_valid_i,
  output logic            trans_ready_o,
  input  mem_pkg::addr_t  trans_addr_i,
  input  logic            trans_we_i,
  input  mem_pkg::be_t    trans_be_i,
  input  mem_pkg::data_t  trans_wdata_i,

  // Transaction response side, the consumer never stalls
  output logic            resp_valid_o,
  output mem_pkg::data_t  resp_rdata_o,
  output logic            resp_err_o,

  // OBI A channel
  output logic            obi_req_o,
  input  logic            obi_gnt_i,
  output mem_pkg::addr_t  obi_addr_o,
  output logic            obi_we_o,
  output mem_pkg::be_t    obi_be_o,
  output mem_pkg::data_t  obi_wdata_o,

  // OBI R channel
  input  logic            obi_rvalid_i,
  input  mem_pkg::data_t  obi_rdata_i,
  input  logic            obi_err_i
);

  mem_pkg::adapter_state_e state_q, state_d;

  // Copy of the A channel taken when a request goes ungranted
  mem_pkg::addr_t addr_q;
  logic           we_q;
  mem_pkg::be_t   be_q;
  mem_pkg::data_t wdata_q;

  //////////////////////////////////////////////////////////////////////////
  // R channel
  //////////////////////////////////////////////////////////////////////////

  // Responses go straight back without any buffering or added latency
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;
  assign resp_err_o   = obi_err_i;

  //////////////////////////////////////////////////////////////////////////
  // A channel FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // A request seen without a grant must be frozen from the next cycle on,
      // since the trans inputs are free to change once accepted
      mem_pkg::TRANSPARENT: begin
        if (trans_valid_i && !obi_gnt_i) begin
          state_d = mem_pkg::REGISTERED;
        end
      end
      // Stay here until the held request is granted
      mem_pkg::REGISTERED: begin
        if (obi_gnt_i) begin
          state_d = mem_pkg::TRANSPARENT;
        end
      end
      default: state_d = mem_pkg::TRANSPARENT;
    endcase
  end

  // Pick the A channel source from the current state
  always_comb begin
    if (state_q == mem_pkg::TRANSPARENT) begin
      obi_req_o   = trans_valid_i;
      obi_addr_o  = trans_addr_i;
      obi_we_o    = trans_we_i;
      obi_be_o    = trans_be_i;
      obi_wdata_o = trans_wdata_i;
    end else begin
      // A pending request is never retracted nor altered
      obi_req_o   = 1'b1;
      obi_addr_o  = addr_q;
      obi_we_o    = we_q;
      obi_be_o    = be_q;
      obi_wdata_o = wdata_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mem_pkg::TRANSPARENT;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture only on the step into REGISTERED
  always_ff @(posedge clk) begin
    if (state_q == mem_pkg::TRANSPARENT && state_d == mem_pkg::REGISTERED) begin
      addr_q  <= trans_addr_i;
      we_q    <= trans_we_i;
      be_q    <= trans_be_i;
      wdata_q <= trans_wdata_i;
    end
  end

  // New work is taken whenever the A channel is not busy holding a request
  assign trans_ready_o = (state_q == mem_pkg::TRANSPARENT);

endmodule

/* design/req_sequencer.sv */
module req_sequencer (
  input  logic            clk,
  input  logic            rst_n,

  // Four-phase requester side
  input  logic            req_i,
  input  mem_pkg::addr_t  addr_i,
  input  logic            we_i,
  input  mem_pkg::be_t    be_i,
  input  mem_pkg::data_t  wdata_i,
  output logic            ack_o,
  output mem_pkg::data_t  rdata_o,
  output logic            err_o,

  // Transaction request towards the adapter
  output logic            trans_valid_o,
  input  logic            trans_ready_i,
  output mem_pkg::addr_t  trans_addr_o,
  output logic            trans_we_o,
  output mem_pkg::be_t    trans_be_o,
  output mem_pkg::data_t  trans_wdata_o,

  // Transaction response, always accepted
  input  logic            resp_valid_i,
  input  mem_pkg::data_t  resp_rdata_i,
  input  logic            resp_err_i
);

  mem_pkg::seq_state_e state_q, state_d;

  // Request fields captured when req_i is first seen
  mem_pkg::addr_t addr_q;
  logic           we_q;
  mem_pkg::be_t   be_q;
  mem_pkg::data_t wdata_q;

  // Response fields held for the whole ack phase
  mem_pkg::data_t rdata_q;
  logic           err_q;

  //////////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      // The request is registered here, trans_valid follows one cycle later
      mem_pkg::IDLE: begin
        if (req_i) begin
          state_d = mem_pkg::ISSUE;
        end
      end
      // Hold trans_valid until the adapter takes the transaction
      mem_pkg::ISSUE: begin
        if (trans_ready_i) begin
          state_d = mem_pkg::WAIT_RESP;
        end
      end
      // Only one request is open, so the next response is ours
      mem_pkg::WAIT_RESP: begin
        if (resp_valid_i) begin
          state_d = mem_pkg::DONE;
        end
      end
      // Keep ack high until the requester lets go of req_i
      mem_pkg::DONE: begin
        if (!req_i) begin
          state_d = mem_pkg::IDLE;
        end
      end
      default: state_d = mem_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= mem_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload registers load on their own enables
  always_ff @(posedge clk) begin
    if (state_q == mem_pkg::IDLE && req_i) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      be_q    <= be_i;
      wdata_q <= wdata_i;
    end
    if (state_q == mem_pkg::WAIT_RESP && resp_valid_i) begin
      rdata_q <= resp_rdata_i;
      err_q   <= resp_err_i;
    end
  end

  assign trans_valid_o = (state_q == mem_pkg::ISSUE);
  assign trans_addr_o  = addr_q;
  assign trans_we_o    = we_q;
  assign trans_be_o    = be_q;
  assign trans_wdata_o = wdata_q;

  // Ack rises the cycle after resp_valid and falls the cycle after req_i
  assign ack_o   = (state_q == mem_pkg::DONE);
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////////

  // Byte addresses and data words are both one 32-bit word wide
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // One enable bit per byte lane of a data word
  localparam int unsigned BYTE_W = 8;
  localparam int unsigned BE_W   = DATA_W / BYTE_W;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BE_W-1:0]   be_t;

  //////////////////////////////////////////////////////////////////////////
  // State machines
  //////////////////////////////////////////////////////////////////////////

  // Adapter drives the A channel either from its inputs or from its registers
  typedef enum logic {
    TRANSPARENT,
    REGISTERED
  } adapter_state_e;

  // Sequencer walks one four-phase request through the trans port
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RESP,
    DONE
  } seq_state_e;

endpackage
